//--- hp_rx_dma_pkg.sv
/* Receive DMA shared definitions: bus widths, limits, completion TLP
   field codes and the FSM state encodings */
package hp_rx_dma_pkg;

    localparam int HOST_ADDR_W = 64;          // host byte address
    localparam int PAGE_QW_W   = 32;          // page length in qwords
    localparam int BUF_ADDR_W  = 9;           // 512 qword buffer
    localparam int DATA_W      = 64;
    localparam int TAG_W       = 2;
    localparam int CHUNK_QW_W  = 7;           // holds up to 64
    localparam int N_SLOTS     = 2;

    localparam logic [6:0] CPLD_FMT_TYPE = 7'b10_01010;
    localparam logic [2:0] CPL_STATUS_SC = 3'b000;

    typedef enum logic [1:0] {
        ISS_IDLE,                             // wait for the current slot
        ISS_CALC,                             // size the next chunk
        ISS_REQ,                              // wait for a free tag
        ISS_ACK                               // request held until ack
    } issue_state_e;

    typedef enum logic [1:0] {
        WR_HDR,                               // header DW0-DW1
        WR_TAG,                               // DW2 and pad
        WR_DATA,
        WR_SKIP                               // drop up to end of frame
    } wr_state_e;

    typedef enum logic [1:0] {
        TRK_IDLE,
        TRK_COUNT,
        TRK_CHECK,
        TRK_REQ
    } trk_state_e;

endpackage

//--- rd_req_issuer.sv
`timescale 1ns/1ns
/* Read request issuer: serves the host page slots in turn and cuts each
   page into tagged memory-read chunks, then hands the page back */
module rd_req_issuer #(
    parameter int MAX_CHUNK_QW    = 64,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                                   trn_clk,
    input  logic                                   reset_n,
    input  logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0]  hp_addr_i [hp_rx_dma_pkg::N_SLOTS],
    input  logic [hp_rx_dma_pkg::PAGE_QW_W-1:0]    hp_qwords_i [hp_rx_dma_pkg::N_SLOTS],
    input  logic [hp_rx_dma_pkg::N_SLOTS-1:0]      hp_valid_i,
    input  logic                                   rd_ack_i,
    input  logic                                   tag_retire_i,
    output logic [hp_rx_dma_pkg::N_SLOTS-1:0]      hp_free_o,
    output logic                                   rd_req_o,
    output logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0]  rd_addr_o,
    output logic [hp_rx_dma_pkg::CHUNK_QW_W-1:0]   rd_qwords_o,
    output logic [hp_rx_dma_pkg::TAG_W-1:0]        rd_tag_o,
    output logic                                   req_fire_o,
    output logic [hp_rx_dma_pkg::BUF_ADDR_W-1:0]   req_buf_base_o,
    output logic                                   req_slot_o,
    output logic [hp_rx_dma_pkg::N_SLOTS-1:0]      page_start_o
);

    localparam int AW  = hp_rx_dma_pkg::HOST_ADDR_W;
    localparam int PQW = hp_rx_dma_pkg::PAGE_QW_W;
    localparam int CQW = hp_rx_dma_pkg::CHUNK_QW_W;
    localparam int BAW = hp_rx_dma_pkg::BUF_ADDR_W;
    localparam int OCW = hp_rx_dma_pkg::TAG_W + 1;

    hp_rx_dma_pkg::issue_state_e state;
    logic [PQW-1:0] page_left;               // qwords not yet requested
    logic           cur_slot;
    logic [OCW-1:0] out_cnt;                 // requests in flight

    assign req_fire_o = rd_req_o & rd_ack_i;
    assign req_slot_o = cur_slot;

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            out_cnt <= '0;
        end else if (req_fire_o && !tag_retire_i) begin
            out_cnt <= out_cnt + 1'b1;
        end else if (!req_fire_o && tag_retire_i) begin
            out_cnt <= out_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // chunk issue FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= hp_rx_dma_pkg::ISS_IDLE;
            cur_slot       <= 1'b0;
            rd_req_o       <= 1'b0;
            rd_addr_o      <= '0;
            rd_qwords_o    <= '0;
            rd_tag_o       <= '0;
            req_buf_base_o <= '0;
            page_left      <= '0;
            hp_free_o      <= '0;
            page_start_o   <= '0;
        end else begin
            hp_free_o    <= '0;
            page_start_o <= '0;
            case (state)
                hp_rx_dma_pkg::ISS_IDLE: begin
                    if (hp_valid_i[cur_slot]) begin
                        rd_addr_o              <= hp_addr_i[cur_slot];
                        page_left              <= hp_qwords_i[cur_slot];
                        page_start_o[cur_slot] <= 1'b1;   // arm the slot's tracker
                        state                  <= hp_rx_dma_pkg::ISS_CALC;
                    end
                end
                hp_rx_dma_pkg::ISS_CALC: begin
                    if (page_left > PQW'(MAX_CHUNK_QW)) begin
                        rd_qwords_o <= CQW'(MAX_CHUNK_QW);
                    end else begin
                        rd_qwords_o <= page_left[CQW-1:0];
                    end
                    state <= hp_rx_dma_pkg::ISS_REQ;
                end
                hp_rx_dma_pkg::ISS_REQ: begin
                    if (out_cnt < OCW'(MAX_OUTSTANDING)) begin
                        rd_req_o <= 1'b1;
                        state    <= hp_rx_dma_pkg::ISS_ACK;
                    end
                end
                hp_rx_dma_pkg::ISS_ACK: begin
                    if (rd_ack_i) begin
                        rd_req_o       <= 1'b0;
                        rd_tag_o       <= rd_tag_o + 1'b1;                 // 0,1,2,3 rotation
                        req_buf_base_o <= req_buf_base_o + BAW'(rd_qwords_o);
                        rd_addr_o      <= rd_addr_o + (AW'(rd_qwords_o) << 3);
                        page_left      <= page_left - PQW'(rd_qwords_o);
                        if (page_left == PQW'(rd_qwords_o)) begin
                            hp_free_o[cur_slot] <= 1'b1;                   // last chunk taken
                            cur_slot            <= ~cur_slot;
                            state               <= hp_rx_dma_pkg::ISS_IDLE;
                        end else begin
                            state <= hp_rx_dma_pkg::ISS_CALC;
                        end
                    end
                end
                default: state <= hp_rx_dma_pkg::ISS_IDLE;
            endcase
        end
    end

endmodule

//--- cpl_bram_writer.sv
`timescale 1ns/1ns
/* Completion writer: parses CplD TLPs by tag and writes the byte-swapped
   payload into the buffer, then reports per-slot completion events */
module cpl_bram_writer (
    input  logic                                  trn_clk,
    input  logic                                  reset_n,
    input  logic [hp_rx_dma_pkg::DATA_W-1:0]      trn_rd_i,
    input  logic                                  trn_rsof_n_i,
    input  logic                                  trn_reof_n_i,
    input  logic                                  trn_rsrc_rdy_n_i,
    input  logic                                  trn_rdst_rdy_n_i,
    input  logic                                  req_fire_i,
    input  logic [hp_rx_dma_pkg::TAG_W-1:0]       req_tag_i,
    input  logic [hp_rx_dma_pkg::CHUNK_QW_W-1:0]  req_qwords_i,
    input  logic [hp_rx_dma_pkg::BUF_ADDR_W-1:0]  req_buf_base_i,
    input  logic                                  req_slot_i,
    output logic [hp_rx_dma_pkg::BUF_ADDR_W-1:0]  wr_addr_o,
    output logic [hp_rx_dma_pkg::DATA_W-1:0]      wr_data_o,
    output logic                                  wr_en_o,
    output logic                                  cpl_done_o,
    output logic                                  cpl_slot_o,
    output logic [9:0]                            cpl_dwords_o,
    output logic                                  tag_retire_o
);

    localparam int TW    = hp_rx_dma_pkg::TAG_W;
    localparam int CQW   = hp_rx_dma_pkg::CHUNK_QW_W;
    localparam int BAW   = hp_rx_dma_pkg::BUF_ADDR_W;
    localparam int NTAGS = 1 << TW;

    // per-tag request table
    logic [BAW-1:0] tag_base [NTAGS];
    logic [CQW-1:0] tag_req  [NTAGS];
    logic [CQW-1:0] tag_rcv  [NTAGS];        // qwords landed so far
    logic           tag_slot [NTAGS];

    hp_rx_dma_pkg::wr_state_e state;
    logic           beat_ok;
    logic           hdr_ok;
    logic [TW-1:0]  hdr_tag;
    logic [TW-1:0]  cur_tag;
    logic [9:0]     len_dw;
    logic [BAW-1:0] wr_ptr;
    logic [CQW-1:0] rcv_next;

    function automatic logic [31:0] bswap32(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    assign beat_ok  = !trn_rsrc_rdy_n_i && !trn_rdst_rdy_n_i;
    assign hdr_ok   = (trn_rd_i[62:56] == hp_rx_dma_pkg::CPLD_FMT_TYPE) &&
                      (trn_rd_i[15:13] == hp_rx_dma_pkg::CPL_STATUS_SC);
    assign hdr_tag  = trn_rd_i[40 +: TW];
    assign rcv_next = tag_rcv[cur_tag] + len_dw[CQW:1];

    ////////////////////////////////////////////////////////////////////////////
    // TLP parse FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= hp_rx_dma_pkg::WR_HDR;
            wr_en_o      <= 1'b0;
            cpl_done_o   <= 1'b0;
            tag_retire_o <= 1'b0;
            cur_tag      <= '0;
            len_dw       <= '0;
            wr_ptr       <= '0;
        end else begin
            wr_en_o      <= 1'b0;
            cpl_done_o   <= 1'b0;
            tag_retire_o <= 1'b0;
            if (beat_ok) begin
                case (state)
                    hp_rx_dma_pkg::WR_HDR: begin
                        if (!trn_rsof_n_i) begin
                            len_dw <= trn_rd_i[41:32];
                            if (hdr_ok) begin
                                state <= hp_rx_dma_pkg::WR_TAG;
                            end else if (trn_reof_n_i) begin
                                state <= hp_rx_dma_pkg::WR_SKIP;   // not ours
                            end
                        end
                    end
                    hp_rx_dma_pkg::WR_TAG: begin
                        cur_tag <= hdr_tag;
                        wr_ptr  <= tag_base[hdr_tag] + BAW'(tag_rcv[hdr_tag]);
                        state   <= trn_reof_n_i ? hp_rx_dma_pkg::WR_DATA
                                                : hp_rx_dma_pkg::WR_HDR;
                    end
                    hp_rx_dma_pkg::WR_DATA: begin
                        wr_en_o <= 1'b1;
                        wr_ptr  <= wr_ptr + 1'b1;          // wraps at 512
                        if (!trn_reof_n_i) begin
                            cpl_done_o   <= 1'b1;
                            tag_retire_o <= (rcv_next == tag_req[cur_tag]);
                            state        <= hp_rx_dma_pkg::WR_HDR;
                        end
                    end
                    hp_rx_dma_pkg::WR_SKIP: begin
                        if (!trn_reof_n_i) begin
                            state <= hp_rx_dma_pkg::WR_HDR;
                        end
                    end
                    default: state <= hp_rx_dma_pkg::WR_HDR;
                endcase
            end
        end
    end

    // tables and write data
    always_ff @(posedge trn_clk) begin
        if (req_fire_i) begin
            tag_base[req_tag_i] <= req_buf_base_i;
            tag_req[req_tag_i]  <= req_qwords_i;
            tag_rcv[req_tag_i]  <= '0;
            tag_slot[req_tag_i] <= req_slot_i;
        end
        if (beat_ok && state == hp_rx_dma_pkg::WR_DATA) begin
            wr_addr_o <= wr_ptr;
            wr_data_o <= {bswap32(trn_rd_i[63:32]), bswap32(trn_rd_i[31:0])};
            if (!trn_reof_n_i) begin
                tag_rcv[cur_tag] <= rcv_next;
                cpl_slot_o       <= tag_slot[cur_tag];
                cpl_dwords_o     <= len_dw;
            end
        end
    end

endmodule

//--- page_cpl_tracker.sv
`timescale 1ns/1ns
/* Page completion tracker: sums one slot's received dwords and asks for
   a host notification once the whole page has landed */
module page_cpl_tracker #(
    parameter int SLOT_ID = 0
) (
    input  logic                                  trn_clk,
    input  logic                                  reset_n,
    input  logic                                  page_start_i,
    input  logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0] page_addr_i,
    input  logic [hp_rx_dma_pkg::PAGE_QW_W-1:0]   page_qwords_i,
    input  logic                                  cpl_done_i,
    input  logic                                  cpl_slot_i,
    input  logic [9:0]                            cpl_dwords_i,
    input  logic                                  ntf_grant_i,
    output logic                                  ntf_req_o,
    output logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0] ntf_addr_o
);

    localparam int DCW = hp_rx_dma_pkg::PAGE_QW_W + 1;

    hp_rx_dma_pkg::trk_state_e state;
    logic [DCW-1:0] dw_target;               // twice the page qwords
    logic [DCW-1:0] dw_cnt;

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= hp_rx_dma_pkg::TRK_IDLE;
            ntf_req_o  <= 1'b0;
            ntf_addr_o <= '0;
            dw_target  <= '0;
            dw_cnt     <= '0;
        end else if (page_start_i) begin
            ntf_addr_o <= page_addr_i;
            dw_target  <= {page_qwords_i, 1'b0};
            dw_cnt     <= '0;
            ntf_req_o  <= 1'b0;
            state      <= hp_rx_dma_pkg::TRK_COUNT;
        end else begin
            case (state)
                hp_rx_dma_pkg::TRK_COUNT: begin
                    if (cpl_done_i && cpl_slot_i == 1'(SLOT_ID)) begin
                        dw_cnt <= dw_cnt + DCW'(cpl_dwords_i);
                        state  <= hp_rx_dma_pkg::TRK_CHECK;
                    end
                end
                hp_rx_dma_pkg::TRK_CHECK: begin
                    if (dw_cnt == dw_target) begin
                        ntf_req_o <= 1'b1;                 // page complete
                        state     <= hp_rx_dma_pkg::TRK_REQ;
                    end else begin
                        state <= hp_rx_dma_pkg::TRK_COUNT;
                    end
                end
                hp_rx_dma_pkg::TRK_REQ: begin
                    if (ntf_grant_i) begin
                        ntf_req_o <= 1'b0;
                        state     <= hp_rx_dma_pkg::TRK_IDLE;
                    end
                end
                default: state <= hp_rx_dma_pkg::TRK_IDLE;
            endcase
        end
    end

endmodule

//--- notify_arbiter.sv
`timescale 1ns/1ns
/* Notification arbiter: grants the lowest requesting tracker and runs
   the notify handshake with the host */
module notify_arbiter (
    input  logic                                  trn_clk,
    input  logic                                  reset_n,
    input  logic [hp_rx_dma_pkg::N_SLOTS-1:0]     ntf_req_i,
    input  logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0] ntf_addr_i [hp_rx_dma_pkg::N_SLOTS],
    input  logic                                  notify_ack_i,
    output logic [hp_rx_dma_pkg::N_SLOTS-1:0]     ntf_grant_o,
    output logic                                  notify_o,
    output logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0] notify_msg_o
);

    localparam int NS    = hp_rx_dma_pkg::N_SLOTS;
    localparam int SEL_W = (NS > 1) ? $clog2(NS) : 1;

    logic [SEL_W-1:0] pick;
    logic             any_req;

    // lowest index wins
    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int s = NS - 1; s >= 0; s--) begin
            if (ntf_req_i[s]) begin
                pick    = SEL_W'(s);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            ntf_grant_o  <= '0;
            notify_o     <= 1'b0;
            notify_msg_o <= '0;
        end else begin
            ntf_grant_o <= '0;
            if (|ntf_grant_o) begin
                notify_o <= 1'b1;                          // one cycle after grant
            end else if (notify_o) begin
                notify_o <= !notify_ack_i;
            end else if (any_req) begin
                ntf_grant_o[pick] <= 1'b1;
                notify_msg_o      <= ntf_addr_i[pick];
            end
        end
    end

endmodule

//--- hp_rx_dma_top.sv
`timescale 1ns/1ns
/* Huge page receive DMA top level: read issue, completion write,
   per-slot completion tracking and host notification */
module hp_rx_dma_top #(
    parameter int MAX_CHUNK_QW    = 64,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                                  trn_clk,
    input  logic                                  reset_n,
    input  logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0] hp_addr_i [hp_rx_dma_pkg::N_SLOTS],
    input  logic [hp_rx_dma_pkg::PAGE_QW_W-1:0]   hp_qwords_i [hp_rx_dma_pkg::N_SLOTS],
    input  logic [hp_rx_dma_pkg::N_SLOTS-1:0]     hp_valid_i,
    output logic [hp_rx_dma_pkg::N_SLOTS-1:0]     hp_free_o,
    output logic                                  rd_req_o,
    output logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0] rd_addr_o,
    output logic [hp_rx_dma_pkg::CHUNK_QW_W-1:0]  rd_qwords_o,
    output logic [hp_rx_dma_pkg::TAG_W-1:0]       rd_tag_o,
    input  logic                                  rd_ack_i,
    input  logic [hp_rx_dma_pkg::DATA_W-1:0]      trn_rd_i,
    input  logic                                  trn_rsof_n_i,
    input  logic                                  trn_reof_n_i,
    input  logic                                  trn_rsrc_rdy_n_i,
    input  logic                                  trn_rdst_rdy_n_i,
    output logic [hp_rx_dma_pkg::BUF_ADDR_W-1:0]  wr_addr_o,
    output logic [hp_rx_dma_pkg::DATA_W-1:0]      wr_data_o,
    output logic                                  wr_en_o,
    output logic                                  notify_o,
    output logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0] notify_msg_o,
    input  logic                                  notify_ack_i
);

    logic                                  req_fire;
    logic [hp_rx_dma_pkg::BUF_ADDR_W-1:0]  req_buf_base;
    logic                                  req_slot;
    logic [hp_rx_dma_pkg::N_SLOTS-1:0]     page_start;
    logic                                  tag_retire;
    logic                                  cpl_done;
    logic                                  cpl_slot;
    logic [9:0]                            cpl_dwords;
    logic [hp_rx_dma_pkg::N_SLOTS-1:0]     ntf_req;
    logic [hp_rx_dma_pkg::N_SLOTS-1:0]     ntf_grant;
    logic [hp_rx_dma_pkg::HOST_ADDR_W-1:0] ntf_addr [hp_rx_dma_pkg::N_SLOTS];

    rd_req_issuer #(
        .MAX_CHUNK_QW    (MAX_CHUNK_QW),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_issuer (
        .trn_clk (trn_clk), .reset_n (reset_n),
        .hp_addr_i (hp_addr_i), .hp_qwords_i (hp_qwords_i), .hp_valid_i (hp_valid_i),
        .rd_ack_i (rd_ack_i), .tag_retire_i (tag_retire), .hp_free_o (hp_free_o),
        .rd_req_o (rd_req_o), .rd_addr_o (rd_addr_o), .rd_qwords_o (rd_qwords_o),
        .rd_tag_o (rd_tag_o), .req_fire_o (req_fire), .req_buf_base_o (req_buf_base),
        .req_slot_o (req_slot), .page_start_o (page_start)
    );

    cpl_bram_writer u_writer (
        .trn_clk (trn_clk), .reset_n (reset_n),
        .trn_rd_i (trn_rd_i), .trn_rsof_n_i (trn_rsof_n_i), .trn_reof_n_i (trn_reof_n_i),
        .trn_rsrc_rdy_n_i (trn_rsrc_rdy_n_i), .trn_rdst_rdy_n_i (trn_rdst_rdy_n_i),
        .req_fire_i (req_fire), .req_tag_i (rd_tag_o), .req_qwords_i (rd_qwords_o),
        .req_buf_base_i (req_buf_base), .req_slot_i (req_slot),
        .wr_addr_o (wr_addr_o), .wr_data_o (wr_data_o), .wr_en_o (wr_en_o),
        .cpl_done_o (cpl_done), .cpl_slot_o (cpl_slot), .cpl_dwords_o (cpl_dwords),
        .tag_retire_o (tag_retire)
    );

    for (genvar s = 0; s < hp_rx_dma_pkg::N_SLOTS; s++) begin : g_trk
        page_cpl_tracker #(.SLOT_ID (s)) u_tracker (
            .trn_clk (trn_clk), .reset_n (reset_n),
            .page_start_i (page_start[s]), .page_addr_i (hp_addr_i[s]),
            .page_qwords_i (hp_qwords_i[s]), .cpl_done_i (cpl_done),
            .cpl_slot_i (cpl_slot), .cpl_dwords_i (cpl_dwords),
            .ntf_grant_i (ntf_grant[s]), .ntf_req_o (ntf_req[s]), .ntf_addr_o (ntf_addr[s])
        );
    end

    notify_arbiter u_arbiter (
        .trn_clk (trn_clk), .reset_n (reset_n),
        .ntf_req_i (ntf_req), .ntf_addr_i (ntf_addr), .notify_ack_i (notify_ack_i),
        .ntf_grant_o (ntf_grant), .notify_o (notify_o), .notify_msg_o (notify_msg_o)
    );

endmodule

//--- hp_rx_dma_sva.sv
`timescale 1ns/1ns
/* Receive DMA protocol checks: outstanding reads, page free pulses and the
   notify handshake */
module hp_rx_dma_sva #(
    parameter int MAX_OUTSTANDING = 4
) (
    input logic       trn_clk,
    input logic       reset_n,
    input logic       req_fire,
    input logic       tag_retire,
    input logic [1:0] hp_free_o,
    input logic       notify_o,
    input logic       notify_ack_i
);

    int   in_flight;                          // accepted minus retired
    logic next_free;                          // slot expected to free next

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            in_flight <= 0;
            next_free <= 1'b0;
        end else begin
            in_flight <= in_flight + int'(req_fire) - int'(tag_retire);
            if (|hp_free_o) begin
                next_free <= ~next_free;
            end
        end
    end

    a_outstanding: assert property (@(posedge trn_clk) disable iff (!reset_n)
        in_flight <= MAX_OUTSTANDING) else $error("too many reads outstanding");
    a_free_pulse: assert property (@(posedge trn_clk) disable iff (!reset_n)
        |hp_free_o |=> !(|hp_free_o)) else $error("page free longer than a cycle");
    a_free_order: assert property (@(posedge trn_clk) disable iff (!reset_n)
        |hp_free_o |-> hp_free_o[next_free] && $onehot(hp_free_o))
        else $error("page free out of slot order");
    a_notify_hold: assert property (@(posedge trn_clk) disable iff (!reset_n)
        notify_o && !notify_ack_i |=> notify_o) else $error("notify dropped before ack");

endmodule

bind hp_rx_dma_top hp_rx_dma_sva #(.MAX_OUTSTANDING (MAX_OUTSTANDING)) u_sva (
    .trn_clk (trn_clk), .reset_n (reset_n), .req_fire (req_fire),
    .tag_retire (tag_retire), .hp_free_o (hp_free_o), .notify_o (notify_o),
    .notify_ack_i (notify_ack_i)
);

//--- hp_rx_dma_tb.sv
`timescale 1ns/1ns
/* Receive DMA testbench with host page and completer models and a
   scoreboard for read requests, buffer writes and notifications */
module hp_rx_dma_tb;

    localparam int NPAGES  = 4;
    localparam int MAX_QW  = 200;
    localparam int TIMEOUT = NPAGES * MAX_QW * 40 + 2000;   // cycles

    int page_qw [NPAGES] = '{200, 150, 137, 90};             // wraps the 512 buffer

    logic        trn_clk;
    logic        reset_n;
    logic [63:0] hp_addr [2];
    logic [31:0] hp_qwords [2];
    logic [1:0]  hp_valid;
    logic [1:0]  hp_free_o;
    logic        rd_req_o;
    logic [63:0] rd_addr_o;
    logic [6:0]  rd_qwords_o;
    logic [1:0]  rd_tag_o;
    logic        rd_ack;
    logic [63:0] trn_rd;
    logic        trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n, trn_rdst_rdy_n;
    logic [8:0]  wr_addr_o;
    logic [63:0] wr_data_o;
    logic        wr_en_o, notify_o, notify_ack, notify_prev;
    logic [63:0] notify_msg_o;

    integer seed = 20;
    int     val_errs = 0;
    int     other_errs = 0;
    int     n_notify = 0;
    int     iss_page = 0;
    int     iss_done = 0;
    int     page_written [NPAGES];
    logic [1:0]  tag_ctr;
    logic [8:0]  buf_ptr;
    // accepted requests waiting for completions
    logic [1:0]  rq_tag [$];
    int          rq_qw [$];
    logic [8:0]  rq_base [$];
    int          rq_page [$];
    // expected buffer writes
    logic [8:0]  ew_addr [$];
    logic [63:0] ew_data [$];
    int          ew_page [$];

    hp_rx_dma_top hp_rx_dma_top_i (
        .trn_clk (trn_clk), .reset_n (reset_n), .hp_addr_i (hp_addr),
        .hp_qwords_i (hp_qwords), .hp_valid_i (hp_valid), .hp_free_o (hp_free_o),
        .rd_req_o (rd_req_o), .rd_addr_o (rd_addr_o), .rd_qwords_o (rd_qwords_o),
        .rd_tag_o (rd_tag_o), .rd_ack_i (rd_ack), .trn_rd_i (trn_rd),
        .trn_rsof_n_i (trn_rsof_n), .trn_reof_n_i (trn_reof_n),
        .trn_rsrc_rdy_n_i (trn_rsrc_rdy_n), .trn_rdst_rdy_n_i (trn_rdst_rdy_n),
        .wr_addr_o (wr_addr_o), .wr_data_o (wr_data_o), .wr_en_o (wr_en_o),
        .notify_o (notify_o), .notify_msg_o (notify_msg_o), .notify_ack_i (notify_ack)
    );

    function automatic logic [63:0] page_addr(input int p);
        return 64'h0000_0001_0000_0000 + 64'(p) * 64'h0010_0000;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        assert (exp == act) else begin
            $display("FAILED %s expected %0h actual %0h", name, exp, act);
            val_errs++;
        end
    endtask

    // one beat held until source and destination ready are both low
    task automatic send_beat(input logic [63:0] d, input logic sof, input logic eof);
        logic taken;
        taken = 1'b0;
        trn_rd         <= d;
        trn_rsof_n     <= !sof;
        trn_reof_n     <= !eof;
        trn_rsrc_rdy_n <= 1'b0;
        trn_rdst_rdy_n <= (($random(seed) & 3) == 0);        // random stall
        while (!taken) begin
            @(posedge trn_clk);
            if (!trn_rdst_rdy_n) begin
                taken = 1'b1;
            end else begin
                trn_rdst_rdy_n <= 1'b0;
            end
        end
    endtask

    task automatic send_tlp(input logic [6:0] fmt, input logic [2:0] st,
                            input logic [1:0] tag, input int nqw,
                            input logic [8:0] base, input int pg, input logic good);
        logic [63:0] hdr;
        logic [63:0] d;
        logic [31:0] sw_hi;
        logic [31:0] sw_lo;
        hdr = '0;
        hdr[62:56] = fmt;
        hdr[41:32] = 10'(2 * nqw);
        hdr[15:13] = st;
        send_beat(hdr, 1'b1, 1'b0);
        send_beat({20'h0, 2'b00, tag, 40'h0}, 1'b0, nqw == 0);
        for (int k = 0; k < nqw; k++) begin
            d = {$random(seed), $random(seed)};
            if (good) begin
                sw_hi = {<<8{d[63:32]}};                   // bytes reversed per dword
                sw_lo = {<<8{d[31:0]}};
                ew_addr.push_back(base + 9'(k));
                ew_data.push_back({sw_hi, sw_lo});
                ew_page.push_back(pg);
            end
            send_beat(d, 1'b0, k == nqw - 1);
        end
    endtask

    initial begin
        trn_clk = 1'b0;
        forever #10 trn_clk = ~trn_clk;
    end

    initial begin
        repeat (TIMEOUT) @(posedge trn_clk);
        $display("timeout: %0d of %0d pages notified", n_notify, NPAGES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // host model for read acks, request checks and notify acks
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge trn_clk) begin
        int exp_q;
        if (reset_n) begin
            if (rd_req_o && rd_ack) begin
                exp_q = page_qw[iss_page] - iss_done;
                if (exp_q > 64) exp_q = 64;
                check_val("rd_qwords", 64'(exp_q), 64'(rd_qwords_o));
                check_val("rd_addr", page_addr(iss_page) + 64'(8 * iss_done), rd_addr_o);
                check_val("rd_tag", 64'(tag_ctr), 64'(rd_tag_o));
                rq_tag.push_back(tag_ctr);
                rq_qw.push_back(exp_q);
                rq_base.push_back(buf_ptr);
                rq_page.push_back(iss_page);
                tag_ctr  <= tag_ctr + 2'd1;
                buf_ptr  <= buf_ptr + 9'(exp_q);              // wraps at 512
                iss_done = iss_done + exp_q;
                if (iss_done == page_qw[iss_page]) begin
                    iss_page++;
                    iss_done = 0;
                end
                rd_ack <= 1'b0;
            end else if (rd_req_o && ($random(seed) & 3) == 0) begin
                rd_ack <= 1'b1;
            end
            notify_prev <= notify_o;
            if (notify_o && !notify_prev) begin
                if (n_notify >= NPAGES) begin
                    $display("notify raised with no page left to report");
                    other_errs++;
                end else begin
                    check_val("notify_msg", page_addr(n_notify), notify_msg_o);
                    check_val("page_written", 64'(page_qw[n_notify]),
                              64'(page_written[n_notify]));
                    n_notify++;
                end
            end
            if (notify_ack) begin
                notify_ack <= 1'b0;
            end else if (notify_o && ($random(seed) & 1)) begin
                notify_ack <= 1'b1;
            end
        end
    end

    // buffer write scoreboard
    always @(posedge trn_clk) begin
        if (reset_n && wr_en_o) begin
            if (ew_addr.size() == 0) begin
                $display("buffer write at %0h with none expected", wr_addr_o);
                other_errs++;
            end else begin
                check_val("wr_addr", 64'(ew_addr.pop_front()), 64'(wr_addr_o));
                check_val("wr_data", ew_data.pop_front(), wr_data_o);
                page_written[ew_page.pop_front()]++;
            end
        end
    end

    // completer sends one or two completions per request in tag order
    initial begin
        int          q;
        int          first;
        logic [1:0]  t;
        logic [8:0]  b;
        int          pg;
        @(posedge reset_n);
        @(posedge trn_clk);
        forever begin
            if (rq_tag.size() == 0) begin
                trn_rsrc_rdy_n <= 1'b1;
                @(posedge trn_clk);
            end else begin
                t  = rq_tag.pop_front();
                q  = rq_qw.pop_front();
                b  = rq_base.pop_front();
                pg = rq_page.pop_front();
                if (($random(seed) & 3) == 0) begin
                    if ($random(seed) & 1) begin
                        send_tlp(7'b100_1010, 3'b010, t, 2, b, pg, 1'b0);   // bad status
                    end else begin
                        send_tlp(7'b000_0000, 3'b000, t, 1, b, pg, 1'b0);   // not a CplD
                    end
                end
                first = q;
                if (q > 1 && ($random(seed) & 1)) begin
                    first = 1 + (($random(seed) & 32'h7fff_ffff) % (q - 1));
                end
                send_tlp(7'b100_1010, 3'b000, t, first, b, pg, 1'b1);
                if (first < q) begin
                    send_tlp(7'b100_1010, 3'b000, t, q - first, b + 9'(first), pg, 1'b1);
                end
            end
        end
    end

    // main sequence puts page p in slot p mod 2
    initial begin
        int s;
        reset_n = 1'b0;
        hp_addr = '{64'h0, 64'h0};
        hp_qwords = '{32'h0, 32'h0};
        hp_valid = 2'b00;
        rd_ack = 1'b0;
        trn_rd = '0;
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rdst_rdy_n = 1'b0;
        notify_ack = 1'b0;
        notify_prev = 1'b0;
        tag_ctr = 2'd0;
        buf_ptr = 9'd0;
        foreach (page_written[i]) page_written[i] = 0;
        repeat (5) @(posedge trn_clk);
        reset_n <= 1'b1;
        for (int p = 0; p < NPAGES; p++) begin
            s = p % 2;
            while (p >= 2 && n_notify <= p - 2) @(posedge trn_clk);
            @(posedge trn_clk);
            hp_addr[s]   <= page_addr(p);
            hp_qwords[s] <= 32'(page_qw[p]);
            hp_valid[s]  <= 1'b1;
            do @(posedge trn_clk); while (!hp_free_o[s]);
            hp_valid[s] <= 1'b0;
        end
        while (n_notify < NPAGES) @(posedge trn_clk);
        repeat (20) @(posedge trn_clk);
        if (ew_addr.size() != 0) begin
            $display("%0d expected buffer writes never happened", ew_addr.size());
            other_errs++;
        end
        $display("errors: %0d wrong values, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- hp_rx_dma.f
hp_rx_dma_pkg.sv
rd_req_issuer.sv
cpl_bram_writer.sv
page_cpl_tracker.sv
notify_arbiter.sv
hp_rx_dma_top.sv
hp_rx_dma_sva.sv
hp_rx_dma_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the receive DMA testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module hp_rx_dma_tb \
    -f hp_rx_dma.f -o hp_rx_dma_sim &&
./obj_dir/hp_rx_dma_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "run_sim: simulation ok" ||
{ echo "run_sim: simulation failed"; exit 1; }
